/* dv/lane_seq_stimulus.txt */
# name lane id vfu vl vstart use_vs1 use_vs2 use_vd vs1 vs2 vd hz_vs1 hz_vs2 hz_vd exp_vl exp_vstart
# vfu 1 is the ALU and 2 the MFPU, hazards are hex masks, every other column is decimal
alu_even      0 1 1 16    0     1 1 0  2  3  4 03 00 10 4     0
alu_rem_l0    0 2 1 17    5     1 0 0  5  6  7 04 00 00 5     2
alu_rem_l1    1 3 1 17    5     0 1 0  8  9 10 00 20 01 4     1
alu_l2_17     2 5 1 17    3     1 1 0 11 12 13 00 00 00 4     1
alu_big       3 7 1 1000  13    1 1 0 14 15 16 80 40 00 250   3
alu_noops     2 4 1 8     0     0 0 0  1  2  3 00 00 00 2     0
alu_l1_max    1 0 1 65535 65534 1 1 0 17 18 19 02 08 00 16384 16384
mfpu_l2       2 4 2 23    6     1 1 1 20 21 22 01 02 04 6     1
mfpu_l3       3 5 2 23    7     1 0 1 23 24 25 10 00 40 5     1
mfpu_c_only   1 6 2 9     0     0 0 1 26 27 28 00 00 22 2     0
mfpu_l0_6     0 6 2 6     2     1 1 0 29 30 31 08 10 00 2     1
mfpu_l2_255   2 1 2 255   254   1 1 0  0  1  2 01 80 00 64    63
mfpu_l3_31    3 1 2 31    30    0 1 1  3  4  5 00 04 08 7     7
one_l0        0 3 2 1     0     1 0 1  6  7  8 20 00 00 1     0
zero_l1       1 0 1 1     0     1 1 0  9 10 11 01 00 00 0     0
zero_l3       3 2 2 3     0     1 1 1 12 13 14 00 00 00 0     0
zero_l2_alu   2 7 1 2     0     1 0 0 15 16 17 00 00 00 0     0

/* verilog.f */
common/lane_seq_pkg.sv
logic/operand_cmd_queues.sv
lane_sequencer/pe_req_register.sv
lane_sequencer/vinsn_dispatch.sv
lane_sequencer/lane_sequencer.sv
dv/tb_lane_sequencer.sv

/* run_sim.sh */
#!/bin/sh
# Builds the lane sequencer testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_lane_sequencer
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_lane_sequencer)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation finished: PASS$"; then
  exit 0
fi
exit 1

/* dv/tb_lane_sequencer.sv */
// Testbench for the lane sequencer that replays the request vectors of the stimulus file
`timescale 1ns/10ps

module tb_lane_sequencer import lane_seq_pkg::*; ();

  localparam int TimeoutCycles = 40;

  logic                          clk;
  logic                          rst_n;
  lane_id_t                      lane_id;
  logic                          pe_req_valid, pe_req_ready;
  vinsn_id_t                     req_id;
  vfu_e                          req_vfu;
  vlen_t                         req_vl, req_vstart;
  vreg_t                         req_vs1, req_vs2, req_vd;
  logic                          req_use_vs1, req_use_vs2, req_use_vd;
  vinsn_mask_t                   req_hazard_vs1, req_hazard_vs2, req_hazard_vd;
  vinsn_mask_t                   pe_vinsn_running, vinsn_done, vinsn_running;
  logic        [NrOpQueues-1:0] opq_ready, opq_valid;
  vinsn_id_t   [NrOpQueues-1:0] opq_id;
  vreg_t       [NrOpQueues-1:0] opq_vs;
  vlen_t       [NrOpQueues-1:0] opq_vl, opq_vstart;
  vinsn_mask_t [NrOpQueues-1:0] opq_hazard;
  logic                          alu_ready, mfpu_ready;
  vinsn_mask_t                   alu_done, mfpu_done;
  logic                          vfu_op_valid;
  vinsn_id_t                     vfu_op_id;
  vfu_e                          vfu_op_vfu;
  vlen_t                         vfu_op_vl, vfu_op_vstart;
  vreg_t                         vfu_op_vd;

  // Fields of the current stimulus line
  string test_name;
  int    f_lane, f_id, f_vfu, f_vl, f_vstart, f_u1, f_u2, f_ud;
  int    f_vs1, f_vs2, f_vd, f_h1, f_h2, f_hd, f_exp_vl, f_exp_vst;
  int    seed;

  // Expected operand commands of the current test
  logic [NrOpQueues-1:0] exp_mask;
  int                    exp_vs[NrOpQueues];
  int                    exp_hz[NrOpQueues];

  lane_sequencer dut0 (
    .clk_i(clk), .rst_ni(rst_n), .lane_id_i(lane_id),
    .pe_req_valid_i(pe_req_valid), .pe_req_ready_o(pe_req_ready),
    .req_id_i(req_id), .req_vfu_i(req_vfu), .req_vl_i(req_vl), .req_vstart_i(req_vstart),
    .req_vs1_i(req_vs1), .req_vs2_i(req_vs2), .req_vd_i(req_vd),
    .req_use_vs1_i(req_use_vs1), .req_use_vs2_i(req_use_vs2), .req_use_vd_i(req_use_vd),
    .req_hazard_vs1_i(req_hazard_vs1), .req_hazard_vs2_i(req_hazard_vs2),
    .req_hazard_vd_i(req_hazard_vd),
    .pe_vinsn_running_i(pe_vinsn_running),
    .vinsn_done_o(vinsn_done), .vinsn_running_o(vinsn_running),
    .opq_ready_i(opq_ready), .opq_valid_o(opq_valid), .opq_id_o(opq_id),
    .opq_vs_o(opq_vs), .opq_vl_o(opq_vl), .opq_vstart_o(opq_vstart),
    .opq_hazard_o(opq_hazard),
    .alu_ready_i(alu_ready), .mfpu_ready_i(mfpu_ready),
    .alu_done_i(alu_done), .mfpu_done_i(mfpu_done),
    .vfu_op_valid_o(vfu_op_valid), .vfu_op_id_o(vfu_op_id), .vfu_op_vfu_o(vfu_op_vfu),
    .vfu_op_vl_o(vfu_op_vl), .vfu_op_vstart_o(vfu_op_vstart), .vfu_op_vd_o(vfu_op_vd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%0s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_val(input string what, input int exp_val, input int act_val);
    assert (act_val == exp_val) else begin
      abort_run($sformatf("** Error %0s %0s: expected 0x%0h, actual 0x%0h",
                          test_name, what, exp_val, act_val));
    end
  endtask

  // Queues the unit and use flags select, with the source register and ORed hazards
  task automatic expect_commands;
    exp_mask = '0;
    if (f_vfu == 1) begin
      exp_mask[OpqAluA] = f_u1[0];
      exp_mask[OpqAluB] = f_u2[0];
    end else if (f_vfu == 2) begin
      exp_mask[OpqMfpuA] = f_u1[0];
      exp_mask[OpqMfpuB] = f_u2[0];
      exp_mask[OpqMfpuC] = f_ud[0];
    end
    exp_vs[OpqAluA]  = f_vs1;
    exp_vs[OpqAluB]  = f_vs2;
    exp_vs[OpqMfpuA] = f_vs1;
    exp_vs[OpqMfpuB] = f_vs2;
    exp_vs[OpqMfpuC] = f_vd;
    exp_hz[OpqAluA]  = f_h1 | f_hd;
    exp_hz[OpqAluB]  = f_h2 | f_hd;
    exp_hz[OpqMfpuA] = f_h1 | f_hd;
    exp_hz[OpqMfpuB] = f_h2 | f_hd;
    exp_hz[OpqMfpuC] = f_hd;
  endtask

  task automatic check_op;
    check_val("vfu_op_valid", 1, int'(vfu_op_valid));
    check_val("vfu_op_id", f_id, int'(vfu_op_id));
    check_val("vfu_op_vfu", f_vfu, int'(vfu_op_vfu));
    check_val("vfu_op_vl", f_exp_vl, int'(vfu_op_vl));
    check_val("vfu_op_vstart", f_exp_vst, int'(vfu_op_vstart));
    check_val("vfu_op_vd", f_vd, int'(vfu_op_vd));
  endtask

  task automatic check_queues(input int cleared);
    check_val("opq_valid", int'(exp_mask), int'(opq_valid));
    for (int q = 0; q < NrOpQueues; q++) begin
      if (exp_mask[q]) begin
        check_val($sformatf("opq_id[%0d]", q), f_id, int'(opq_id[q]));
        check_val($sformatf("opq_vs[%0d]", q), exp_vs[q], int'(opq_vs[q]));
        check_val($sformatf("opq_vl[%0d]", q), f_exp_vl, int'(opq_vl[q]));
        check_val($sformatf("opq_vstart[%0d]", q), f_exp_vst, int'(opq_vstart[q]));
        check_val($sformatf("opq_hazard[%0d]", q), exp_hz[q] & ~cleared, int'(opq_hazard[q]));
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////////////////////////

  task automatic send_request;
    int n;
    n = 0;
    pe_req_valid = 1'b1;
    @(negedge clk);
    while (!pe_req_ready) begin
      n++;
      if (n > TimeoutCycles) abort_run($sformatf("Request of %0s was never accepted", test_name));
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    pe_req_valid = 1'b0;
  endtask

  task automatic drain_queues;
    int n;
    n = 0;
    opq_ready = '1;
    @(negedge clk);
    while (opq_valid != '0) begin
      n++;
      if (n > TimeoutCycles) abort_run($sformatf("Operand commands of %0s never left", test_name));
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    opq_ready = '0;
  endtask

  task automatic run_test;
    int clr;
    int stall;
    int fid;
    expect_commands();
    @(posedge clk);
    #1;
    lane_id        = lane_id_t'(f_lane);
    req_id         = vinsn_id_t'(f_id);
    req_vfu        = vfu_e'(f_vfu);
    req_vl         = vlen_t'(f_vl);
    req_vstart     = vlen_t'(f_vstart);
    req_vs1        = vreg_t'(f_vs1);
    req_vs2        = vreg_t'(f_vs2);
    req_vd         = vreg_t'(f_vd);
    req_use_vs1    = f_u1[0];
    req_use_vs2    = f_u2[0];
    req_use_vd     = f_ud[0];
    req_hazard_vs1 = vinsn_mask_t'(f_h1);
    req_hazard_vs2 = vinsn_mask_t'(f_h2);
    req_hazard_vd  = vinsn_mask_t'(f_hd);
    send_request();
    if (f_exp_vl == 0) begin
      // Muted in this lane, it only retires
      @(negedge clk);
      check_val("vinsn_done", 1 << f_id, int'(vinsn_done));
      check_val("vinsn_running", 1 << f_id, int'(vinsn_running));
      check_val("vfu_op_valid", 0, int'(vfu_op_valid));
      check_val("opq_valid", 0, int'(opq_valid));
    end else begin
      // A muted follower request queues up behind the stalled operation
      fid         = f_id ^ 4;
      req_id      = vinsn_id_t'(fid);
      req_vfu     = VFU_NONE;
      req_vl      = '0;
      req_vstart  = '0;
      req_use_vs1 = 1'b0;
      req_use_vs2 = 1'b0;
      req_use_vd  = 1'b0;
      pe_req_valid = 1'b1;
      stall = ($random(seed) & 3) + 1;
      clr = 0;
      for (int q = 0; q < NrOpQueues; q++) begin
        if (exp_mask[q]) clr |= exp_hz[q];
      end
      clr = clr & -clr;
      @(negedge clk);
      check_op();
      check_queues(0);
      check_val("vinsn_running", 1 << f_id, int'(vinsn_running));
      check_val("pe_req_ready empty", 1, int'(pe_req_ready));
      @(posedge clk);
      #1;
      pe_req_valid     = 1'b0;
      pe_vinsn_running = vinsn_mask_t'(~clr);
      for (int k = 0; k < stall; k++) begin
        @(negedge clk);
        check_op();
        check_val("pe_req_ready full", 0, int'(pe_req_ready));
        check_val("vinsn_done stalled", 0, int'(vinsn_done));
        @(posedge clk);
        #1;
      end
      alu_ready  = 1'b1;
      mfpu_ready = 1'b1;
      @(posedge clk);
      #1;
      alu_ready  = 1'b0;
      mfpu_ready = 1'b0;
      @(negedge clk);
      check_val("vfu_op_valid taken", 0, int'(vfu_op_valid));
      check_val("vinsn_done follower", 1 << fid, int'(vinsn_done));
      check_queues(clr);
      @(posedge clk);
      #1;
      drain_queues();
      if (f_vfu == 1) alu_done = vinsn_mask_t'(1 << f_id);
      else mfpu_done = vinsn_mask_t'(1 << f_id);
      @(posedge clk);
      #1;
      alu_done  = '0;
      mfpu_done = '0;
      @(negedge clk);
      check_val("vinsn_done unit", 1 << f_id, int'(vinsn_done));
    end
    // Retire everything so that the IDs can be reused
    @(posedge clk);
    #1;
    pe_vinsn_running = '0;
    @(posedge clk);
    #1;
    pe_vinsn_running = '1;
    @(negedge clk);
    check_val("vinsn_running flushed", 0, int'(vinsn_running));
  endtask

  initial begin
    int                fd;
    int                n;
    int                tests;
    string             line;
    logic [8*32-1:0]   name_raw;
    seed             = 32;
    tests            = 0;
    rst_n            = 1'b0;
    lane_id          = '0;
    pe_req_valid     = 1'b0;
    req_id           = '0;
    req_vfu          = VFU_NONE;
    req_vl           = '0;
    req_vstart       = '0;
    req_vs1          = '0;
    req_vs2          = '0;
    req_vd           = '0;
    req_use_vs1      = 1'b0;
    req_use_vs2      = 1'b0;
    req_use_vd       = 1'b0;
    req_hazard_vs1   = '0;
    req_hazard_vs2   = '0;
    req_hazard_vd    = '0;
    pe_vinsn_running = '1;
    opq_ready        = '0;
    alu_ready        = 1'b0;
    mfpu_ready       = 1'b0;
    alu_done         = '0;
    mfpu_done        = '0;
    test_name        = "reset";
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("dv/lane_seq_stimulus.txt", "r");
    if (fd == 0) abort_run("Cannot open the stimulus file dv/lane_seq_stimulus.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() > 1 && line.substr(0, 0) != "#") begin
        n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %h %h %h %d %d", name_raw,
                    f_lane, f_id, f_vfu, f_vl, f_vstart, f_u1, f_u2, f_ud,
                    f_vs1, f_vs2, f_vd, f_h1, f_h2, f_hd, f_exp_vl, f_exp_vst);
        if (n != 17) abort_run($sformatf("Stimulus line cannot be parsed: %0s", line));
        test_name = $sformatf("%0s", name_raw);
        run_test();
        tests++;
      end
    end
    $fclose(fd);
    if (tests == 0) begin
      abort_run("The stimulus file holds no test");
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* lane_sequencer/lane_sequencer.sv */
// Per-lane instruction sequencer top level joining the request register, dispatcher and operand queues
`timescale 1ns/10ps

module lane_sequencer import lane_seq_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  lane_id_t                      lane_id_i,
  // Main sequencer
  input  logic                          pe_req_valid_i,
  output logic                          pe_req_ready_o,
  input  vinsn_id_t                     req_id_i,
  input  vfu_e                          req_vfu_i,
  input  vlen_t                         req_vl_i,
  input  vlen_t                         req_vstart_i,
  input  vreg_t                         req_vs1_i,
  input  vreg_t                         req_vs2_i,
  input  vreg_t                         req_vd_i,
  input  logic                          req_use_vs1_i,
  input  logic                          req_use_vs2_i,
  input  logic                          req_use_vd_i,
  input  vinsn_mask_t                   req_hazard_vs1_i,
  input  vinsn_mask_t                   req_hazard_vs2_i,
  input  vinsn_mask_t                   req_hazard_vd_i,
  input  vinsn_mask_t                   pe_vinsn_running_i,
  output vinsn_mask_t                   vinsn_done_o,
  output vinsn_mask_t                   vinsn_running_o,
  // Operand requester
  input  logic        [NrOpQueues-1:0] opq_ready_i,
  output logic        [NrOpQueues-1:0] opq_valid_o,
  output vinsn_id_t   [NrOpQueues-1:0] opq_id_o,
  output vreg_t       [NrOpQueues-1:0] opq_vs_o,
  output vlen_t       [NrOpQueues-1:0] opq_vl_o,
  output vlen_t       [NrOpQueues-1:0] opq_vstart_o,
  output vinsn_mask_t [NrOpQueues-1:0] opq_hazard_o,
  // Lane units
  input  logic                          alu_ready_i,
  input  logic                          mfpu_ready_i,
  input  vinsn_mask_t                   alu_done_i,
  input  vinsn_mask_t                   mfpu_done_i,
  output logic                          vfu_op_valid_o,
  output vinsn_id_t                     vfu_op_id_o,
  output vfu_e                          vfu_op_vfu_o,
  output vlen_t                         vfu_op_vl_o,
  output vlen_t                         vfu_op_vstart_o,
  output vreg_t                         vfu_op_vd_o
);

  // Buffered request
  logic        reg_valid, reg_ready;
  vinsn_id_t   reg_id;
  vfu_e        reg_vfu;
  vlen_t       reg_vl, reg_vstart;
  vreg_t       reg_vs1, reg_vs2, reg_vd;
  logic        reg_use_vs1, reg_use_vs2, reg_use_vd;
  vinsn_mask_t reg_hazard_vs1, reg_hazard_vs2, reg_hazard_vd;

  // Operand commands
  logic        [NrOpQueues-1:0] opq_push, opq_busy;
  vinsn_id_t   [NrOpQueues-1:0] cmd_id;
  vreg_t       [NrOpQueues-1:0] cmd_vs;
  vlen_t       [NrOpQueues-1:0] cmd_vl, cmd_vstart;
  vinsn_mask_t [NrOpQueues-1:0] cmd_hazard;

  pe_req_register i_pe_req_register (
    .clk_i, .rst_ni,
    .valid_i(pe_req_valid_i), .ready_o(pe_req_ready_o),
    .req_id_i, .req_vfu_i, .req_vl_i, .req_vstart_i,
    .req_vs1_i, .req_vs2_i, .req_vd_i,
    .req_use_vs1_i, .req_use_vs2_i, .req_use_vd_i,
    .req_hazard_vs1_i, .req_hazard_vs2_i, .req_hazard_vd_i,
    .valid_o(reg_valid), .ready_i(reg_ready),
    .req_id_o(reg_id), .req_vfu_o(reg_vfu), .req_vl_o(reg_vl), .req_vstart_o(reg_vstart),
    .req_vs1_o(reg_vs1), .req_vs2_o(reg_vs2), .req_vd_o(reg_vd),
    .req_use_vs1_o(reg_use_vs1), .req_use_vs2_o(reg_use_vs2), .req_use_vd_o(reg_use_vd),
    .req_hazard_vs1_o(reg_hazard_vs1), .req_hazard_vs2_o(reg_hazard_vs2),
    .req_hazard_vd_o(reg_hazard_vd)
  );

  vinsn_dispatch i_vinsn_dispatch (
    .clk_i, .rst_ni, .lane_id_i,
    .req_valid_i(reg_valid), .req_ready_o(reg_ready),
    .req_id_i(reg_id), .req_vfu_i(reg_vfu), .req_vl_i(reg_vl), .req_vstart_i(reg_vstart),
    .req_vs1_i(reg_vs1), .req_vs2_i(reg_vs2), .req_vd_i(reg_vd),
    .req_use_vs1_i(reg_use_vs1), .req_use_vs2_i(reg_use_vs2), .req_use_vd_i(reg_use_vd),
    .req_hazard_vs1_i(reg_hazard_vs1), .req_hazard_vs2_i(reg_hazard_vs2),
    .req_hazard_vd_i(reg_hazard_vd),
    .pe_vinsn_running_i,
    .opq_busy_i(opq_busy), .opq_push_o(opq_push),
    .cmd_id_o(cmd_id), .cmd_vs_o(cmd_vs), .cmd_vl_o(cmd_vl),
    .cmd_vstart_o(cmd_vstart), .cmd_hazard_o(cmd_hazard),
    .alu_ready_i, .mfpu_ready_i, .alu_done_i, .mfpu_done_i,
    .vinsn_done_o, .vinsn_running_o,
    .vfu_op_valid_o, .vfu_op_id_o, .vfu_op_vfu_o,
    .vfu_op_vl_o, .vfu_op_vstart_o, .vfu_op_vd_o
  );

  operand_cmd_queues i_operand_cmd_queues (
    .clk_i, .rst_ni,
    .push_i(opq_push),
    .cmd_id_i(cmd_id), .cmd_vs_i(cmd_vs), .cmd_vl_i(cmd_vl),
    .cmd_vstart_i(cmd_vstart), .cmd_hazard_i(cmd_hazard),
    .pe_vinsn_running_i,
    .opq_ready_i,
    .opq_busy_o(opq_busy),
    .opq_valid_o, .opq_id_o, .opq_vs_o, .opq_vl_o, .opq_vstart_o, .opq_hazard_o
  );

endmodule

/* lane_sequencer/vinsn_dispatch.sv */
// Lane issue logic that splits the vector length and posts the VFU operation and operand commands
`timescale 1ns/10ps

module vinsn_dispatch import lane_seq_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  lane_id_t                      lane_id_i,
  // Request from the request register
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  input  vinsn_id_t                     req_id_i,
  input  vfu_e                          req_vfu_i,
  input  vlen_t                         req_vl_i,
  input  vlen_t                         req_vstart_i,
  input  vreg_t                         req_vs1_i,
  input  vreg_t                         req_vs2_i,
  input  vreg_t                         req_vd_i,
  input  logic                          req_use_vs1_i,
  input  logic                          req_use_vs2_i,
  input  logic                          req_use_vd_i,
  input  vinsn_mask_t                   req_hazard_vs1_i,
  input  vinsn_mask_t                   req_hazard_vs2_i,
  input  vinsn_mask_t                   req_hazard_vd_i,
  input  vinsn_mask_t                   pe_vinsn_running_i,
  // Operand command queues
  input  logic        [NrOpQueues-1:0] opq_busy_i,
  output logic        [NrOpQueues-1:0] opq_push_o,
  output vinsn_id_t   [NrOpQueues-1:0] cmd_id_o,
  output vreg_t       [NrOpQueues-1:0] cmd_vs_o,
  output vlen_t       [NrOpQueues-1:0] cmd_vl_o,
  output vlen_t       [NrOpQueues-1:0] cmd_vstart_o,
  output vinsn_mask_t [NrOpQueues-1:0] cmd_hazard_o,
  // Lane units
  input  logic                          alu_ready_i,
  input  logic                          mfpu_ready_i,
  input  vinsn_mask_t                   alu_done_i,
  input  vinsn_mask_t                   mfpu_done_i,
  output vinsn_mask_t                   vinsn_done_o,
  output vinsn_mask_t                   vinsn_running_o,
  output logic                          vfu_op_valid_o,
  output vinsn_id_t                     vfu_op_id_o,
  output vfu_e                          vfu_op_vfu_o,
  output vlen_t                         vfu_op_vl_o,
  output vlen_t                         vfu_op_vstart_o,
  output vreg_t                         vfu_op_vd_o
);

  // Elements of a length that fall on this lane, the low lanes take the remainder
  function automatic vlen_t lane_share(vlen_t len, lane_id_t lane);
    lane_share = (len >> LaneIdW) + vlen_t'(lane < len[LaneIdW-1:0]);
  endfunction

  vinsn_mask_t running_live, id_onehot;
  vlen_t       vl_lane, vstart_lane;
  logic        unit_ready, target_busy, hold, accept, mute;

  assign vl_lane     = lane_share(req_vl_i, lane_id_i);
  assign vstart_lane = lane_share(req_vstart_i, lane_id_i);
  assign id_onehot   = vinsn_mask_t'(1) << req_id_i;

  // Instructions drop out as soon as the main sequencer retires them
  assign running_live = vinsn_running_o & pe_vinsn_running_i;

  always_comb begin
    unique case (vfu_op_vfu_o)
      VFU_ALU:  unit_ready = alu_ready_i;
      VFU_MFPU: unit_ready = mfpu_ready_i;
      default:  unit_ready = 1'b1;
    endcase
    unique case (req_vfu_i)
      VFU_ALU:  target_busy = |opq_busy_i[OpqAluB:OpqAluA];
      VFU_MFPU: target_busy = |opq_busy_i[OpqMfpuC:OpqMfpuA];
      default:  target_busy = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Acceptance
  ////////////////////////////////////////////////////////////

  assign hold        = vfu_op_valid_o && !unit_ready;
  assign req_ready_o = !hold && !target_busy && !running_live[req_id_i];
  assign accept      = req_valid_i && req_ready_o;
  // Nothing to execute in this lane, so the instruction retires at once
  assign mute        = accept && (vl_lane == '0);

  always_comb begin
    opq_push_o = '0;
    for (int q = 0; q < NrOpQueues; q++) begin
      cmd_id_o[q]     = req_id_i;
      cmd_vl_o[q]     = vl_lane;
      cmd_vstart_o[q] = vstart_lane;
    end
    cmd_vs_o[OpqAluA]      = req_vs1_i;
    cmd_vs_o[OpqAluB]      = req_vs2_i;
    cmd_vs_o[OpqMfpuA]     = req_vs1_i;
    cmd_vs_o[OpqMfpuB]     = req_vs2_i;
    cmd_vs_o[OpqMfpuC]     = req_vd_i;
    cmd_hazard_o[OpqAluA]  = req_hazard_vs1_i | req_hazard_vd_i;
    cmd_hazard_o[OpqAluB]  = req_hazard_vs2_i | req_hazard_vd_i;
    cmd_hazard_o[OpqMfpuA] = req_hazard_vs1_i | req_hazard_vd_i;
    cmd_hazard_o[OpqMfpuB] = req_hazard_vs2_i | req_hazard_vd_i;
    cmd_hazard_o[OpqMfpuC] = req_hazard_vd_i;
    if (accept && !mute) begin
      if (req_vfu_i == VFU_ALU) begin
        opq_push_o[OpqAluA] = req_use_vs1_i;
        opq_push_o[OpqAluB] = req_use_vs2_i;
      end
      if (req_vfu_i == VFU_MFPU) begin
        opq_push_o[OpqMfpuA] = req_use_vs1_i;
        opq_push_o[OpqMfpuB] = req_use_vs2_i;
        opq_push_o[OpqMfpuC] = req_use_vd_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Operation register and instruction tracking
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      vfu_op_valid_o  <= 1'b0;
      vinsn_done_o    <= '0;
      vinsn_running_o <= '0;
    end else begin
      vfu_op_valid_o  <= hold || (accept && !mute);
      vinsn_done_o    <= alu_done_i | mfpu_done_i | (mute ? id_onehot : '0);
      vinsn_running_o <= running_live | (accept ? id_onehot : '0);
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      vfu_op_id_o     <= req_id_i;
      vfu_op_vfu_o    <= req_vfu_i;
      vfu_op_vl_o     <= vl_lane;
      vfu_op_vstart_o <= vstart_lane;
      vfu_op_vd_o     <= req_vd_i;
    end
  end

  a_op_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    hold |=> vfu_op_valid_o && $stable(vfu_op_vfu_o)
             && $stable({vfu_op_id_o, vfu_op_vl_o, vfu_op_vstart_o, vfu_op_vd_o}))
    else $error("VFU operation changed under back-pressure");

  a_push_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (opq_push_o & opq_busy_i) == '0)
    else $error("Operand command pushed to a busy queue");

endmodule

/* lane_sequencer/pe_req_register.sv */
// One-entry fall-through register that buffers the main sequencer request for the lane dispatcher
`timescale 1ns/10ps

module pe_req_register import lane_seq_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  // Request from the main sequencer
  input  logic        valid_i,
  output logic        ready_o,
  input  vinsn_id_t   req_id_i,
  input  vfu_e        req_vfu_i,
  input  vlen_t       req_vl_i,
  input  vlen_t       req_vstart_i,
  input  vreg_t       req_vs1_i,
  input  vreg_t       req_vs2_i,
  input  vreg_t       req_vd_i,
  input  logic        req_use_vs1_i,
  input  logic        req_use_vs2_i,
  input  logic        req_use_vd_i,
  input  vinsn_mask_t req_hazard_vs1_i,
  input  vinsn_mask_t req_hazard_vs2_i,
  input  vinsn_mask_t req_hazard_vd_i,
  // Request towards the dispatcher
  output logic        valid_o,
  input  logic        ready_i,
  output vinsn_id_t   req_id_o,
  output vfu_e        req_vfu_o,
  output vlen_t       req_vl_o,
  output vlen_t       req_vstart_o,
  output vreg_t       req_vs1_o,
  output vreg_t       req_vs2_o,
  output vreg_t       req_vd_o,
  output logic        req_use_vs1_o,
  output logic        req_use_vs2_o,
  output logic        req_use_vd_o,
  output vinsn_mask_t req_hazard_vs1_o,
  output vinsn_mask_t req_hazard_vs2_o,
  output vinsn_mask_t req_hazard_vd_o
);

  localparam int unsigned ReqW = $bits(vinsn_id_t) + 2 * $bits(vlen_t) + 3 * $bits(vreg_t)
                                 + 3 + 3 * $bits(vinsn_mask_t);

  logic            full_q;
  logic            load;
  logic [ReqW-1:0] data_in, data_q, data_out;
  vfu_e            vfu_q;

  assign data_in = {req_id_i, req_vl_i, req_vstart_i, req_vs1_i, req_vs2_i, req_vd_i,
                    req_use_vs1_i, req_use_vs2_i, req_use_vd_i,
                    req_hazard_vs1_i, req_hazard_vs2_i, req_hazard_vd_i};

  // An empty register shows the incoming request directly
  assign data_out  = full_q ? data_q : data_in;
  assign req_vfu_o = full_q ? vfu_q : req_vfu_i;
  assign {req_id_o, req_vl_o, req_vstart_o, req_vs1_o, req_vs2_o, req_vd_o,
          req_use_vs1_o, req_use_vs2_o, req_use_vd_o,
          req_hazard_vs1_o, req_hazard_vs2_o, req_hazard_vd_o} = data_out;

  assign valid_o = full_q || valid_i;
  assign ready_o = !full_q || ready_i;

  // Store the input unless it falls straight through to the dispatcher
  assign load = valid_i && (full_q ? ready_i : !ready_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (full_q) begin
      if (ready_i) full_q <= valid_i;
    end else begin
      full_q <= valid_i && !ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_in;
      vfu_q  <= req_vfu_i;
    end
  end

  // A request offered to the dispatcher and not taken is still offered, unchanged, next cycle
  a_held_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_out) && $stable(req_vfu_o))
    else $error("Held request changed while not taken");

endmodule

/* logic/operand_cmd_queues.sv */
// Single-entry operand command slots whose hazard bits are cleared as older instructions retire
`timescale 1ns/10ps

module operand_cmd_queues import lane_seq_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic        [NrOpQueues-1:0] push_i,
  input  vinsn_id_t   [NrOpQueues-1:0] cmd_id_i,
  input  vreg_t       [NrOpQueues-1:0] cmd_vs_i,
  input  vlen_t       [NrOpQueues-1:0] cmd_vl_i,
  input  vlen_t       [NrOpQueues-1:0] cmd_vstart_i,
  input  vinsn_mask_t [NrOpQueues-1:0] cmd_hazard_i,
  input  vinsn_mask_t                   pe_vinsn_running_i,
  input  logic        [NrOpQueues-1:0] opq_ready_i,
  output logic        [NrOpQueues-1:0] opq_busy_o,
  output logic        [NrOpQueues-1:0] opq_valid_o,
  output vinsn_id_t   [NrOpQueues-1:0] opq_id_o,
  output vreg_t       [NrOpQueues-1:0] opq_vs_o,
  output vlen_t       [NrOpQueues-1:0] opq_vl_o,
  output vlen_t       [NrOpQueues-1:0] opq_vstart_o,
  output vinsn_mask_t [NrOpQueues-1:0] opq_hazard_o
);

  // A slot being taken this cycle can already accept the next command
  assign opq_busy_o = opq_valid_o & ~opq_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opq_valid_o  <= '0;
      opq_hazard_o <= '0;
    end else begin
      for (int q = 0; q < NrOpQueues; q++) begin
        if (push_i[q]) begin
          opq_valid_o[q]  <= 1'b1;
          opq_hazard_o[q] <= cmd_hazard_i[q] & pe_vinsn_running_i;
        end else begin
          if (opq_ready_i[q]) begin
            opq_valid_o[q] <= 1'b0;
          end
          // Hazards on instructions that stopped running are gone
          opq_hazard_o[q] <= opq_hazard_o[q] & pe_vinsn_running_i;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOpQueues; q++) begin
      if (push_i[q]) begin
        opq_id_o[q]     <= cmd_id_i[q];
        opq_vs_o[q]     <= cmd_vs_i[q];
        opq_vl_o[q]     <= cmd_vl_i[q];
        opq_vstart_o[q] <= cmd_vstart_i[q];
      end
    end
  end

  a_no_overwrite: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i & opq_valid_o & ~opq_ready_i) == '0)
    else $error("Operand command overwrote a pending slot");

endmodule

/* common/lane_seq_pkg.sv */
// Lane constants, widths and the unit selector shared by the lane sequencer RTL and testbench
package lane_seq_pkg;

  ////////////////////////////////////////////////////////////
  // Lane geometry
  ////////////////////////////////////////////////////////////

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned NrVInsn    = 8;
  localparam int unsigned NrOpQueues = 5;

  localparam int unsigned LaneIdW  = $clog2(NrLanes);
  localparam int unsigned VInsnIdW = $clog2(NrVInsn);
  localparam int unsigned VlenW    = 16;
  localparam int unsigned VregW    = 5;

  // Positions of the operand queues in every per-queue vector
  localparam int unsigned OpqAluA  = 0;
  localparam int unsigned OpqAluB  = 1;
  localparam int unsigned OpqMfpuA = 2;
  localparam int unsigned OpqMfpuB = 3;
  localparam int unsigned OpqMfpuC = 4;

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic [VInsnIdW-1:0] vinsn_id_t;
  typedef logic [NrVInsn-1:0]  vinsn_mask_t;
  typedef logic [LaneIdW-1:0]  lane_id_t;
  typedef logic [VlenW-1:0]    vlen_t;
  typedef logic [VregW-1:0]    vreg_t;

  // Functional unit that executes an instruction inside the lane
  typedef enum logic [1:0] {
    VFU_NONE = 2'd0,
    VFU_ALU  = 2'd1,
    VFU_MFPU = 2'd2
  } vfu_e;

endpackage
